//--- hdl/hps_pkg.sv
////////////////////////////////////////
// host bridge keyboard path definitions
// bus, key event and line types, command
// codes and keyboard scancode sequences
////////////////////////////////////////

package hps_pkg;

	////////////////////////////////////////
	// host commands
	////////////////////////////////////////

	localparam logic [15:0] CMD_JOY0   = 16'h0002;
	localparam logic [15:0] CMD_KBD    = 16'h0005;
	localparam logic [15:0] CMD_STATUS = 16'h001E;

	// marker that makes the rest of a keyboard frame ignored
	localparam logic [7:0] SKIP_MARKER = 8'hFF;

	////////////////////////////////////////
	// scancode prefixes and sequences
	////////////////////////////////////////

	localparam logic [7:0] BREAK_PREFIX = 8'hF0;
	localparam logic [7:0] EXT_PREFIX   = 8'hE0;

	// newest byte sits in the low byte of the history
	localparam logic [31:0] SEQ_PRNSCR_MAKE  = 32'hE012E07C;
	localparam logic [31:0] SEQ_PRNSCR_BREAK = 32'h7CE0F012;
	localparam logic [31:0] SEQ_PAUSE        = 32'hF014F077;

	////////////////////////////////////////
	// types
	////////////////////////////////////////

	// host word bus, enable frames a transfer, strobe marks a word
	typedef struct packed {
		logic        strobe;
		logic        enable;
		logic [15:0] din;
	} io_bus_t;

	// keyboard data word as seen by the bridge
	typedef struct packed {
		logic [7:0] marker;
		logic [7:0] scancode;
	} kbd_word_t;

	typedef union packed {
		logic [15:0] raw;
		kbd_word_t   kbd;
	} io_word_u;

	// alternative key event, toggle flips on every update
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	// one ps/2 line pair, 1 means released
	typedef struct packed {
		logic clk;
		logic dat;
	} ps2_line_t;

endpackage

//--- hdl/io_cmd_decoder.sv
////////////////////////////////////////
// host command decoder
// takes framed host words and updates the
// joystick, status and key event outputs,
// pushes keyboard scancodes to the fifo
////////////////////////////////////////

`timescale 1ns/1ps

module io_cmd_decoder (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  hps_pkg::io_bus_t   io_bus,
	output logic [31:0]        joystick_0,
	output logic [63:0]        status,
	output hps_pkg::ps2_key_t  ps2_key,
	output logic               push,
	output logic [7:0]         push_data
);

	logic [15:0]       cmd;
	logic [3:0]        byte_cnt;
	logic              skip;
	logic [31:0]       kbd_raw;
	hps_pkg::io_word_u kbd_word;
	logic              data_strobe;
	logic              kbd_accept;
	logic              key_pressed;
	hps_pkg::ps2_key_t key_next;

	assign kbd_word.raw = io_bus.din;

	// a data word is any strobe after the command word
	assign data_strobe = io_bus.enable && io_bus.strobe && (byte_cnt != 4'd0);

	assign kbd_accept = data_strobe && (cmd == hps_pkg::CMD_KBD) && !skip &&
		(kbd_word.kbd.marker != hps_pkg::SKIP_MARKER);

	////////////////////////////////////////
	// key event from the scancode history
	////////////////////////////////////////

	assign key_pressed = (kbd_raw[15:8] != hps_pkg::BREAK_PREFIX);

	always_comb begin
		key_next.toggle   = ~ps2_key.toggle;
		key_next.pressed  = key_pressed;
		// on release the extended prefix sits before the break prefix
		key_next.extended = key_pressed ? (kbd_raw[15:8] == hps_pkg::EXT_PREFIX) :
			(kbd_raw[23:16] == hps_pkg::EXT_PREFIX);
		key_next.code     = kbd_raw[7:0];

		case (kbd_raw)
			hps_pkg::SEQ_PRNSCR_MAKE: begin
				key_next.pressed  = 1'b1;
				key_next.extended = 1'b1;
				key_next.code     = 8'h7C;
			end
			hps_pkg::SEQ_PRNSCR_BREAK: begin
				key_next.pressed  = 1'b0;
				key_next.extended = 1'b1;
				key_next.code     = 8'h7C;
			end
			hps_pkg::SEQ_PAUSE: begin
				key_next.pressed  = 1'b1;
				key_next.extended = 1'b1;
				key_next.code     = 8'h77;
			end
			default: begin
			end
		endcase
	end

	////////////////////////////////////////
	// frame handling
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cmd        <= '0;
			byte_cnt   <= '0;
			skip       <= 1'b0;
			joystick_0 <= '0;
			status     <= '0;
			ps2_key    <= '0;
			push       <= 1'b0;
		end else begin
			push <= kbd_accept;

			if (!io_bus.enable) begin
				// frame over, publish the key event once
				if (cmd == hps_pkg::CMD_KBD && !skip)
					ps2_key <= key_next;
				cmd      <= '0;
				byte_cnt <= '0;
				skip     <= 1'b0;
			end else if (io_bus.strobe) begin
				if (!(&byte_cnt))
					byte_cnt <= byte_cnt + 4'd1;

				if (byte_cnt == 4'd0) begin
					cmd <= io_bus.din;
				end else begin
					case (cmd)
						hps_pkg::CMD_JOY0: begin
							if (byte_cnt == 4'd1)
								joystick_0[15:0] <= io_bus.din;
							else if (byte_cnt == 4'd2)
								joystick_0[31:16] <= io_bus.din;
						end
						hps_pkg::CMD_STATUS: begin
							case (byte_cnt)
								4'd1: status[15:0]  <= io_bus.din;
								4'd2: status[31:16] <= io_bus.din;
								4'd3: status[47:32] <= io_bus.din;
								4'd4: status[63:48] <= io_bus.din;
								default: begin
								end
							endcase
						end
						hps_pkg::CMD_KBD: begin
							if (kbd_word.kbd.marker == hps_pkg::SKIP_MARKER)
								skip <= 1'b1;
						end
						default: begin
						end
					endcase
				end
			end
		end
	end

	// scancode history and fifo byte
	always_ff @(posedge clk_sys) begin
		if (io_bus.enable && io_bus.strobe && byte_cnt == 4'd0 &&
			io_bus.din == hps_pkg::CMD_KBD) begin
			kbd_raw <= '0;
		end else if (kbd_accept) begin
			kbd_raw   <= {kbd_raw[23:0], kbd_word.kbd.scancode};
			push_data <= kbd_word.kbd.scancode;
		end
	end

endmodule

//--- hdl/scancode_fifo.sv
////////////////////////////////////////
// scancode fifo
// first-word-fall-through byte buffer,
// writes into a full fifo are dropped
////////////////////////////////////////

`timescale 1ns/1ps

module scancode_fifo #(
	parameter int FIFO_BITS = 5
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       push,
	input  logic [7:0] push_data,
	input  logic       pop,
	output logic       empty,
	output logic [7:0] head
);

	localparam int DEPTH = 1 << FIFO_BITS;

	logic [7:0]         mem [DEPTH];
	// extra top bit tells a full fifo from an empty one
	logic [FIFO_BITS:0] wptr;
	logic [FIFO_BITS:0] rptr;
	logic               full;

	assign empty = (wptr == rptr);
	assign full  = (wptr[FIFO_BITS] != rptr[FIFO_BITS]) &&
		(wptr[FIFO_BITS-1:0] == rptr[FIFO_BITS-1:0]);

	assign head = mem[rptr[FIFO_BITS-1:0]];

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push && !full)
				wptr <= wptr + 1'b1;
			if (pop && !empty)
				rptr <= rptr + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (push && !full)
			mem[wptr[FIFO_BITS-1:0]] <= push_data;
	end

endmodule

//--- hdl/ps2_kbd_tx.sv
////////////////////////////////////////
// ps/2 keyboard transmitter
// divides clk_sys into the ps/2 clock and
// sends fifo bytes as device-to-host
// frames on the emulated keyboard lines
////////////////////////////////////////

`timescale 1ns/1ps

module ps2_kbd_tx #(
	parameter int PS2_DIV = 2000
) (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                empty,
	input  logic [7:0]          head,
	input  hps_pkg::ps2_line_t  ps2_kbd_in,
	output logic                pop,
	output hps_pkg::ps2_line_t  ps2_kbd_out
);

	localparam int DIV_W = (PS2_DIV > 0) ? $clog2(PS2_DIV + 1) : 1;

	logic [DIV_W-1:0]   div_cnt;
	logic               clk_ps2;
	logic               clk_ps2_d;
	logic               ps2_rise;
	logic               ps2_fall;
	hps_pkg::ps2_line_t line_s1;
	hps_pkg::ps2_line_t line_s2;
	logic               lines_idle;
	logic [1:0]         timeout;
	logic [3:0]         tx_state;
	logic [7:0]         tx_byte;
	logic               parity;

	////////////////////////////////////////
	// ps/2 clock and line sensing
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			div_cnt   <= '0;
			clk_ps2   <= 1'b0;
			clk_ps2_d <= 1'b0;
			line_s1   <= '1;
			line_s2   <= '1;
		end else begin
			clk_ps2_d <= clk_ps2;
			line_s1   <= ps2_kbd_in;
			line_s2   <= line_s1;
			if (div_cnt == DIV_W'(PS2_DIV)) begin
				div_cnt <= '0;
				clk_ps2 <= ~clk_ps2;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	assign ps2_rise = clk_ps2 & ~clk_ps2_d;
	assign ps2_fall = ~clk_ps2 & clk_ps2_d;

	// host is not inhibiting either line
	assign lines_idle = line_s1.clk & line_s2.clk & line_s1.dat & line_s2.dat;

	////////////////////////////////////////
	// frame serializer
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			timeout     <= 2'd3;
			tx_state    <= '0;
			pop         <= 1'b0;
			ps2_kbd_out <= '1;
		end else begin
			pop <= 1'b0;

			if (ps2_rise) begin
				// clock line goes back up on every rise
				ps2_kbd_out.clk <= 1'b1;

				if (tx_state == 4'd0) begin
					if (!empty && lines_idle) begin
						timeout <= timeout - 2'd1;
						if (timeout == 2'd0) begin
							timeout         <= 2'd3;
							pop             <= 1'b1;
							tx_state        <= 4'd1;
							ps2_kbd_out.dat <= 1'b0;
						end
					end else begin
						timeout <= 2'd3;
					end
				end else begin
					if (tx_state <= 4'd8)
						ps2_kbd_out.dat <= tx_byte[0];
					else if (tx_state == 4'd9)
						ps2_kbd_out.dat <= parity;
					else if (tx_state == 4'd10)
						ps2_kbd_out.dat <= 1'b1;

					if (tx_state < 4'd11)
						tx_state <= tx_state + 4'd1;
					else
						tx_state <= 4'd0;
				end
			end

			// falling edge pulls the clock only inside a frame
			if (ps2_fall)
				ps2_kbd_out.clk <= (tx_state == 4'd0);
		end
	end

	// data shift register and odd parity
	always_ff @(posedge clk_sys) begin
		if (ps2_rise) begin
			if (tx_state == 4'd0) begin
				tx_byte <= head;
				parity  <= 1'b1;
			end else if (tx_state <= 4'd8) begin
				tx_byte <= {1'b0, tx_byte[7:1]};
				parity  <= parity ^ tx_byte[0];
			end
		end
	end

endmodule

//--- hdl/hps_kbd_link.sv
////////////////////////////////////////
// host keyboard link
// host command decoder, scancode fifo and
// ps/2 keyboard transmitter
////////////////////////////////////////

`timescale 1ns/1ps

module hps_kbd_link #(
	parameter int FIFO_BITS = 5,
	parameter int PS2_DIV   = 2000
) (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  hps_pkg::io_bus_t    io_bus,
	input  hps_pkg::ps2_line_t  ps2_kbd_in,
	output logic [31:0]         joystick_0,
	output logic [63:0]         status,
	output hps_pkg::ps2_key_t   ps2_key,
	output hps_pkg::ps2_line_t  ps2_kbd_out
);

	logic       push;
	logic [7:0] push_data;
	logic       pop;
	logic       empty;
	logic [7:0] head;

	io_cmd_decoder dec0 (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.io_bus     (io_bus),
		.joystick_0 (joystick_0),
		.status     (status),
		.ps2_key    (ps2_key),
		.push       (push),
		.push_data  (push_data)
	);

	scancode_fifo #(
		.FIFO_BITS (FIFO_BITS)
	) fifo0 (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.empty     (empty),
		.head      (head)
	);

	ps2_kbd_tx #(
		.PS2_DIV (PS2_DIV)
	) tx0 (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.empty       (empty),
		.head        (head),
		.ps2_kbd_in  (ps2_kbd_in),
		.pop         (pop),
		.ps2_kbd_out (ps2_kbd_out)
	);

endmodule

//--- tests/tb_hps_kbd_link.sv
////////////////////////////////////////
// host keyboard link testbench
// directed frames on the host bus, ps/2
// loopback and a frame monitor on the
// emulated keyboard lines
////////////////////////////////////////

`timescale 1ns/1ps

module tb_hps_kbd_link;

	localparam int TB_PS2_DIV   = 3;
	localparam int TB_FIFO_BITS = 5;
	localparam int PS2_PERIOD   = 2 * (TB_PS2_DIV + 1);
	localparam int KBD_BYTES    = 17;
	localparam int CYCLE_LIMIT  = 2000 + 40 * PS2_PERIOD * KBD_BYTES;

	logic               clk_sys;
	logic               rst_n;
	hps_pkg::io_bus_t   io_bus;
	hps_pkg::ps2_line_t ps2_kbd_in;
	logic [31:0]        joystick_0;
	logic [63:0]        status;
	hps_pkg::ps2_key_t  ps2_key;
	hps_pkg::ps2_line_t ps2_kbd_out;

	int          errors = 0;
	int          checks = 0;
	int          cycle_cnt = 0;
	logic        exp_toggle = 1'b0;
	logic [7:0]  sent_q[$];
	logic [7:0]  rx_q[$];
	logic [10:0] rx_bits = '0;
	int          rx_count = 0;

	hps_kbd_link #(
		.FIFO_BITS (TB_FIFO_BITS),
		.PS2_DIV   (TB_PS2_DIV)
	) dut0 (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.io_bus      (io_bus),
		.ps2_kbd_in  (ps2_kbd_in),
		.joystick_0  (joystick_0),
		.status      (status),
		.ps2_key     (ps2_key),
		.ps2_kbd_out (ps2_kbd_out)
	);

	// host side never inhibits the keyboard lines
	assign ps2_kbd_in = ps2_kbd_out;

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT) begin
			$display("timeout: run still busy after %0d clock cycles", CYCLE_LIMIT);
			$display("Errors found");
			$finish;
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic compare_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// device-to-host frames are sampled on the falling clock with the start bit first
	always @(negedge ps2_kbd_out.clk) begin
		if (rst_n) begin
			rx_bits = {ps2_kbd_out.dat, rx_bits[10:1]};
			rx_count++;
			if (rx_count == 11) begin
				compare_value("start bit", rx_bits[0], 1'b0);
				compare_value("odd parity", ^rx_bits[9:1], 1'b1);
				compare_value("stop bit", rx_bits[10], 1'b1);
				rx_q.push_back(rx_bits[8:1]);
				rx_count = 0;
			end
		end
	end

	task automatic send_frame(input logic [15:0] cmd, input logic [15:0] words[$]);
		@(posedge clk_sys);
		io_bus.enable <= 1'b1;
		io_bus.strobe <= 1'b1;
		io_bus.din    <= cmd;
		foreach (words[i]) begin
			@(posedge clk_sys);
			io_bus.strobe <= 1'b0;
			@(posedge clk_sys);
			io_bus.strobe <= 1'b1;
			io_bus.din    <= words[i];
		end
		@(posedge clk_sys);
		io_bus.strobe <= 1'b0;
		@(posedge clk_sys);
		io_bus.enable <= 1'b0;
		// key event lands one cycle after enable is seen low
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	// sends the low n bytes of seq with the oldest in the highest used byte
	task automatic send_kbd_bytes(input int n, input logic [31:0] seq);
		logic [15:0] words[$];
		logic [7:0]  code;
		for (int i = n - 1; i >= 0; i--) begin
			code = seq[8*i +: 8];
			words.push_back({8'h00, code});
			sent_q.push_back(code);
		end
		send_frame(hps_pkg::CMD_KBD, words);
		exp_toggle = ~exp_toggle;
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic check_reset;
		int start_err;
		start_err = errors;
		@(negedge clk_sys);
		compare_value("joystick_0 after reset", joystick_0, 32'h0);
		compare_value("status after reset", status, 64'h0);
		compare_value("ps2_key after reset", ps2_key, 11'h0);
		compare_value("ps2_kbd_out after reset", ps2_kbd_out, 2'b11);
		$display("check_reset finished, %0d errors", errors - start_err);
	endtask

	task automatic test_joystick_status;
		int          start_err;
		logic [15:0] words[$];
		start_err = errors;
		words.push_back(16'h5A21);
		words.push_back(16'hC3F0);
		send_frame(hps_pkg::CMD_JOY0, words);
		compare_value("joystick_0", joystick_0, 32'hC3F0_5A21);
		words.delete();
		words.push_back(16'h0123);
		words.push_back(16'h4567);
		words.push_back(16'h89AB);
		words.push_back(16'hCDEF);
		send_frame(hps_pkg::CMD_STATUS, words);
		compare_value("status", status, 64'hCDEF_89AB_4567_0123);
		$display("test_joystick_status finished, %0d errors", errors - start_err);
	endtask

	task automatic test_key_events;
		int start_err;
		start_err = errors;
		send_kbd_bytes(1, 32'h0000_001C);
		compare_value("ps2_key for 1C", ps2_key, {exp_toggle, 1'b1, 1'b0, 8'h1C});
		send_kbd_bytes(2, 32'h0000_F01C);
		compare_value("ps2_key for F0 1C", ps2_key, {exp_toggle, 1'b0, 1'b0, 8'h1C});
		send_kbd_bytes(2, 32'h0000_E075);
		compare_value("ps2_key for E0 75", ps2_key, {exp_toggle, 1'b1, 1'b1, 8'h75});
		$display("test_key_events finished, %0d errors", errors - start_err);
	endtask

	task automatic test_special_and_skip;
		int                start_err;
		logic [15:0]       words[$];
		hps_pkg::ps2_key_t key_before;
		start_err = errors;
		send_kbd_bytes(4, 32'hE012_E07C);
		compare_value("print screen key bits", ps2_key[9:0], 10'h37C);
		compare_value("print screen toggle", ps2_key.toggle, exp_toggle);
		// released print screen and pause replace the plain decode
		send_kbd_bytes(4, 32'h7CE0_F012);
		compare_value("print screen release", ps2_key, {exp_toggle, 1'b0, 1'b1, 8'h7C});
		send_kbd_bytes(4, 32'hF014_F077);
		compare_value("pause key", ps2_key, {exp_toggle, 1'b1, 1'b1, 8'h77});
		// marker 0xFF drops the whole frame
		key_before = ps2_key;
		words.push_back(16'hFF12);
		words.push_back(16'h0034);
		send_frame(hps_pkg::CMD_KBD, words);
		compare_value("ps2_key after skipped frame", ps2_key, key_before);
		$display("test_special_and_skip finished, %0d errors", errors - start_err);
	endtask

	task automatic test_ps2_serial;
		int start_err;
		start_err = errors;
		while (rx_q.size() < sent_q.size())
			@(posedge clk_sys);
		// wait long enough that an extra frame would show up
		repeat (20 * PS2_PERIOD) @(posedge clk_sys);
		@(negedge clk_sys);
		compare_value("received byte count", rx_q.size(), sent_q.size());
		foreach (sent_q[i]) begin
			if (i < rx_q.size())
				compare_value($sformatf("received byte %0d", i), rx_q[i], sent_q[i]);
		end
		compare_value("ps2_kbd_out when idle", ps2_kbd_out, 2'b11);
		$display("test_ps2_serial finished, %0d errors", errors - start_err);
	endtask

	initial begin
		io_bus = '0;
		rst_n  = 1'b0;
		repeat (2) @(posedge clk_sys);
		rst_n <= 1'b1;
		check_reset();
		test_joystick_status();
		test_key_events();
		test_special_and_skip();
		test_ps2_serial();
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- compile.f
hdl/hps_pkg.sv
hdl/io_cmd_decoder.sv
hdl/scancode_fifo.sv
hdl/ps2_kbd_tx.sv
hdl/hps_kbd_link.sv
tests/tb_hps_kbd_link.sv

//--- Bender.yml
package:
  name: hps_kbd_link

sources:
  - hdl/hps_pkg.sv
  - hdl/io_cmd_decoder.sv
  - hdl/scancode_fifo.sv
  - hdl/ps2_kbd_tx.sv
  - hdl/hps_kbd_link.sv
  - target: test
    files:
      - tests/tb_hps_kbd_link.sv
